//--- Makefile
TOP = sdmac_datapath_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sdmac_datapath.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- bench/sdmac_datapath_tb.sv
// testbench for the scsi dma byte-lane datapath
// clock and reset, apb master tasks, scsi chip model with lfsr dreq gaps
// reference model for byte and word streams, compare process, watchdog
module sdmac_datapath_tb;
    import sdmac_pkg::*;

    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 4;
    // bytes moved over all transfers below
    localparam int TOTAL_BYTES = 12 + 16 + 6 + 6 + 24 + 4;
    localparam int LIMIT_CYC   = TOTAL_BYTES * 20 + 2000;

    logic        LS2CPU;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        dreq;
    logic        dack;
    logic [7:0]  scsi_dout;
    logic        scsi_doe;
    logic [7:0]  scsi_din;

    logic [31:0] lfsr_q = 32'h6a7;
    logic        apb_err;
    int          apb_wait;
    logic        dreq_enable;
    logic        rx_phase;
    int          moved_cnt;
    int          moved_seen;
    logic        held_valid;
    logic [7:0]  held_byte;
    // host words, chip bytes, expected and observed streams
    logic [31:0] host_words[$];
    logic [7:0]  rx_src[$];
    logic [7:0]  exp_bytes[$];
    logic [7:0]  obs_bytes[$];
    logic [31:0] exp_words[$];
    logic [31:0] obs_words[$];

    sdmac_datapath #(
        .COUNT_W    (COUNT_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdmac_datapath_inst (
        .LS2CPU    (LS2CPU),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .dreq      (dreq),
        .dack      (dack),
        .scsi_dout (scsi_dout),
        .scsi_doe  (scsi_doe),
        .scsi_din  (scsi_din)
    );

    always #50 LS2CPU = ~LS2CPU;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        assert (got == want) else
            fail_run($sformatf("Error: time %0t, signal %s, expected %h, got %h",
                               $time, name, want, got));
    endtask

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken, bits shifted in from the lsb
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // expected scsi bytes, lane 3 of each host word first
    function automatic void build_tx_ref(input int count);
        for (int i = 0; i < count; i++) begin
            exp_bytes.push_back(8'(host_words[i / 4] >> (24 - 8 * (i % 4))));
        end
    endfunction

    // expected host words, first byte in lane 3, unused lanes zero
    function automatic void build_rx_ref(input int count);
        logic [31:0] w;
        for (int n = 0; n < (count + 3) / 4; n++) begin
            w = '0;
            for (int l = 0; l < 4; l++) begin
                if (4 * n + l < count) begin
                    w = w | (32'(rx_src[4 * n + l]) << (24 - 8 * l));
                end
            end
            exp_words.push_back(w);
        end
    endfunction

    // setup phase, then access phase held until pready
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge LS2CPU);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge LS2CPU);
        penable  = 1'b1;
        apb_wait = 0;
        #20;
        while (!pready) begin
            @(negedge LS2CPU);
            #20;
            apb_wait++;
        end
        rdata   = prdata;
        apb_err = pslverr;
        // bytes that moved up to the edge before this sample
        moved_seen = moved_cnt;
        // completing edge lies before this negedge
        @(negedge LS2CPU);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic prepare_tx(input int count);
        rx_phase = 1'b0;
        apb_write(ADDR_CTRL, 32'h0);
        apb_write(ADDR_COUNT, 32'(count));
        host_words.delete();
        for (int i = 0; i < (count + 3) / 4; i++) begin
            host_words.push_back(rand_bits(32));
        end
        build_tx_ref(count);
        moved_cnt = 0;
    endtask

    task automatic prepare_rx(input int count);
        rx_phase = 1'b1;
        apb_write(ADDR_CTRL, 32'h2);
        apb_write(ADDR_COUNT, 32'(count));
        rx_src.delete();
        // one random byte per handshake on scsi_din
        for (int i = 0; i < count; i++) begin
            rx_src.push_back(8'(rand_bits(8)));
        end
        build_rx_ref(count);
        moved_cnt = 0;
    endtask

    task automatic read_words(input int n);
        logic [31:0] rd;
        for (int i = 0; i < n; i++) begin
            apb_read(ADDR_DATA, rd);
            assert (!apb_err) else fail_run("data read returned pslverr during receive");
            obs_words.push_back(rd);
        end
    endtask

    // count seen by the host is the loaded value minus moved bytes
    task automatic check_count(input int loaded);
        logic [31:0] rd;
        apb_read(ADDR_COUNT, rd);
        check_value("COUNT", 32'(loaded - moved_seen), rd);
    endtask

    task automatic finish_transfer();
        logic [31:0] st;
        st = 32'h1;
        while (st[0]) begin
            apb_read(ADDR_STATUS, st);
        end
        while (obs_bytes.size() > 0 || obs_words.size() > 0) begin
            @(negedge LS2CPU);
        end
        assert (exp_bytes.size() == 0) else fail_run("transfer ended before all bytes left");
        assert (exp_words.size() == 0) else fail_run("transfer ended before all words came back");
        // idle and fifo empty
        check_value("STATUS", 32'h2, st);
    endtask

    // scsi chip model, dreq driven on the falling edge
    always @(negedge LS2CPU) begin
        dreq     = dreq_enable ? (rand_bits(2) != 0) : 1'b0;
        scsi_din = (rx_src.size() > 0) ? rx_src[0] : 8'h00;
        // late in the low phase, after the apb sample point
        #30;
        if (held_valid) begin
            check_value("dack", 32'h1, 32'(dack));
            check_value("scsi_dout", 32'(held_byte), 32'(scsi_dout));
        end
        if (dreq && dack) begin
            if (rx_phase) begin
                check_value("scsi_doe", 32'h0, 32'(scsi_doe));
                assert (rx_src.size() > 0) else
                    fail_run("receive took more bytes than the transfer count");
                void'(rx_src.pop_front());
            end else begin
                check_value("scsi_doe", 32'h1, 32'(scsi_doe));
                obs_bytes.push_back(scsi_dout);
            end
            moved_cnt++;
        end
        // without dreq the pending byte must stay put
        held_valid = !rx_phase && dack && !dreq;
        held_byte  = scsi_dout;
    end

    // compare observed streams with the reference
    always @(negedge LS2CPU) begin : compare
        logic [7:0]  want_b;
        logic [7:0]  got_b;
        logic [31:0] want_w;
        logic [31:0] got_w;
        while (obs_bytes.size() > 0) begin
            got_b = obs_bytes.pop_front();
            assert (exp_bytes.size() > 0) else fail_run("scsi side sent a byte beyond the count");
            want_b = exp_bytes.pop_front();
            check_value("scsi_dout", 32'(want_b), 32'(got_b));
        end
        while (obs_words.size() > 0) begin
            got_w = obs_words.pop_front();
            assert (exp_words.size() > 0) else fail_run("host read more words than expected");
            want_w = exp_words.pop_front();
            check_value("prdata", want_w, got_w);
        end
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge LS2CPU);
        fail_run("watchdog expired, the transfers did not finish");
    end

    initial begin
        logic [31:0] rd;
        LS2CPU      = 1'b0;
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 8'h00;
        pwdata      = 32'h0;
        dreq        = 1'b0;
        scsi_din    = 8'h00;
        dreq_enable = 1'b0;
        rx_phase    = 1'b0;
        moved_cnt   = 0;
        held_valid  = 1'b0;
        held_byte   = 8'h00;
        repeat (4) @(negedge LS2CPU);
        arst_n = 1'b1;

        // idle status, then an unmapped address
        apb_read(ADDR_STATUS, rd);
        check_value("STATUS", 32'h2, rd);
        apb_read(8'h10, rd);
        assert (apb_err) else fail_run("read of an unmapped address did not raise pslverr");

        // memory to scsi, three words under random dreq gaps
        dreq_enable = 1'b1;
        prepare_tx(12);
        apb_write(ADDR_CTRL, 32'h1);
        apb_write(ADDR_DATA, host_words[0]);
        check_count(12);
        apb_write(ADDR_DATA, host_words[1]);
        check_count(12);
        apb_write(ADDR_DATA, host_words[2]);
        finish_transfer();

        // scsi to memory, four words
        prepare_rx(16);
        apb_write(ADDR_CTRL, 32'h3);
        read_words(4);
        finish_transfer();

        // partial word both ways
        prepare_tx(6);
        apb_write(ADDR_CTRL, 32'h1);
        apb_write(ADDR_DATA, host_words[0]);
        apb_write(ADDR_DATA, host_words[1]);
        finish_transfer();
        prepare_rx(6);
        apb_write(ADDR_CTRL, 32'h3);
        read_words(2);
        finish_transfer();

        // transmit back-pressure, one word held and four queued
        dreq_enable = 1'b0;
        prepare_tx(24);
        apb_write(ADDR_CTRL, 32'h1);
        for (int i = 0; i < 5; i++) begin
            apb_write(ADDR_DATA, host_words[i]);
        end
        apb_read(ADDR_STATUS, rd);
        check_value("STATUS", 32'h5, rd);
        check_count(24);
        fork
            begin
                repeat (8) @(negedge LS2CPU);
                dreq_enable = 1'b1;
            end
        join_none
        apb_write(ADDR_DATA, host_words[5]);
        assert (apb_wait > 0) else fail_run("data write into a full FIFO did not wait");
        finish_transfer();

        // receive read on an empty fifo waits for the word
        dreq_enable = 1'b0;
        prepare_rx(4);
        apb_write(ADDR_CTRL, 32'h3);
        fork
            begin
                repeat (8) @(negedge LS2CPU);
                dreq_enable = 1'b1;
            end
        join_none
        read_words(1);
        assert (apb_wait > 0) else fail_run("data read from an empty FIFO did not wait");
        finish_transfer();

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- design/scsi_byte_port.sv
// scsi chip side of the datapath
// dreq/dack handshake, registered output byte with its enable
// latched input byte handed to the packer for one cycle
module scsi_byte_port (
    input  logic       LS2CPU,
    input  logic       arst_n,
    input  logic       rx_mode,
    input  logic       tx_valid,
    input  logic [7:0] tx_byte,
    output logic       byte_taken,
    output logic       rx_valid,
    output logic [7:0] rx_byte,
    input  logic       dreq,
    output logic       dack,
    output logic [7:0] scsi_dout,
    output logic       scsi_doe,
    input  logic [7:0] scsi_din
);
    logic       tx_pend;
    logic       tx_load;
    logic [7:0] tx_q;
    logic       rx_hs;
    logic       rx_valid_q;
    logic [7:0] rx_q;

    // transmit byte loads when the output register is free
    assign tx_load    = ~tx_pend & ~rx_mode & tx_valid;
    // byte leaves on the edge with dreq and dack both high
    assign byte_taken = tx_pend & dreq;
    // receive handshake, rx_mode is only high while the packer has room
    assign rx_hs      = rx_mode & dreq;

    assign dack       = tx_pend | rx_mode;
    assign scsi_doe   = tx_pend;
    assign scsi_dout  = tx_q;
    assign rx_valid   = rx_valid_q;
    assign rx_byte    = rx_q;

    always_ff @(posedge LS2CPU or negedge arst_n) begin
        if (!arst_n) begin
            tx_pend    <= 1'b0;
            rx_valid_q <= 1'b0;
        end else begin
            if (byte_taken) begin
                tx_pend <= 1'b0;
            end else if (tx_load) begin
                tx_pend <= 1'b1;
            end
            // one cycle strobe per received byte
            rx_valid_q <= rx_hs;
        end
    end

    always_ff @(posedge LS2CPU) begin
        if (tx_load) begin
            tx_q <= tx_byte;
        end
        if (rx_hs) begin
            rx_q <= scsi_din;
        end
    end

endmodule

//--- design/scsi_lane_packer.sv
// byte lane packer between the longword fifo and the scsi byte port
// lane offset 3 down to 0, byte select on transmit, byte assembly on receive
// byte counter ends the transfer, a partial word is flushed zero filled
module scsi_lane_packer #(
    parameter int COUNT_W = 16
) (
    input  logic                   LS2CPU,
    input  logic                   arst_n,
    input  logic                   start,
    input  sdmac_pkg::dir_e        dir,
    input  logic [COUNT_W-1:0]     count_load,
    output logic                   busy,
    output logic [COUNT_W-1:0]     count_left,
    input  sdmac_pkg::sdmac_word_u fifo_head,
    input  logic                   fifo_empty,
    input  logic                   fifo_full,
    output logic                   fifo_pop,
    output logic                   fifo_push,
    output sdmac_pkg::sdmac_word_u fifo_wdata,
    output logic                   tx_valid,
    output logic [7:0]             tx_byte,
    input  logic                   byte_taken,
    input  logic                   rx_valid,
    input  logic [7:0]             rx_byte,
    output logic                   rx_mode
);
    import sdmac_pkg::*;

    logic               busy_q;
    dir_e               dir_q;
    logic [COUNT_W-1:0] count_q;
    logic [1:0]         lane_q;
    logic               have_q;
    sdmac_word_u        hold_q;
    sdmac_word_u        asm_q;
    sdmac_word_u        asm_next;
    logic               load;
    logic               tx_active;
    logic               rx_active;
    logic               last_byte;
    logic               word_done;
    logic               moved;

    assign load       = start & ~busy_q;
    assign tx_active  = busy_q & (dir_q == DIR_F2S);
    assign rx_active  = busy_q & (dir_q == DIR_S2F);
    assign last_byte  = (count_q == COUNT_W'(1));
    assign busy       = busy_q;
    assign count_left = count_q;

    // transmit, fetch a new longword once the held one is used up
    assign fifo_pop   = tx_active & ~have_q & ~fifo_empty;
    assign tx_valid   = tx_active & have_q;
    // byte mux, lane offset picks the byte of the held word
    assign tx_byte    = hold_q.lane[lane_q];

    // receive, drop the incoming byte into its lane
    always_comb begin
        asm_next = asm_q;
        asm_next.lane[lane_q] = rx_byte;
    end

    // word complete after lane 0 or on the last counted byte
    assign word_done  = rx_active & rx_valid & ((lane_q == 2'd0) | last_byte);
    assign fifo_push  = word_done & ~fifo_full;
    assign fifo_wdata = asm_next;
    // room for a byte: fifo not full and no push going out this cycle
    assign rx_mode    = rx_active & ~fifo_full & ~word_done;

    assign moved      = (tx_active & byte_taken) | (rx_active & rx_valid);

    always_ff @(posedge LS2CPU or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            dir_q   <= DIR_F2S;
            count_q <= '0;
            lane_q  <= 2'd3;
            have_q  <= 1'b0;
        end else if (load) begin
            // a zero count never starts
            busy_q  <= (count_load != '0);
            dir_q   <= dir;
            count_q <= count_load;
            lane_q  <= 2'd3;
            have_q  <= 1'b0;
        end else begin
            if (fifo_pop) begin
                have_q <= 1'b1;
            end
            if (moved) begin
                count_q <= count_q - COUNT_W'(1);
                // wraps from lane 0 back to lane 3
                lane_q  <= lane_q - 2'd1;
                if ((lane_q == 2'd0) || last_byte) begin
                    have_q <= 1'b0;
                end
                if (last_byte) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // word registers
    always_ff @(posedge LS2CPU) begin
        if (fifo_pop) begin
            hold_q <= fifo_head;
        end
        // cleared after each push so unused lanes of a partial word are zero
        if (load) begin
            asm_q <= '0;
        end else if (rx_active && rx_valid) begin
            asm_q <= word_done ? '0 : asm_next;
        end
    end

endmodule

//--- design/sdmac_apb_regs.sv
// apb slave for the scsi dma datapath
// ctrl, count, status and data registers
// data register accesses map onto fifo push and pop, with wait states
module sdmac_apb_regs #(
    parameter int COUNT_W = 16
) (
    input  logic                   LS2CPU,
    input  logic                   arst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic                   fifo_full,
    input  logic                   fifo_empty,
    input  sdmac_pkg::sdmac_word_u fifo_head,
    output logic                   fifo_push,
    output logic                   fifo_pop,
    output sdmac_pkg::sdmac_word_u fifo_wdata,
    output logic                   start,
    output sdmac_pkg::dir_e        dir,
    output logic [COUNT_W-1:0]     count_load,
    input  logic                   busy,
    input  logic [COUNT_W-1:0]     count_left
);
    import sdmac_pkg::*;

    logic               access;
    logic               hit_ctrl;
    logic               hit_count;
    logic               hit_status;
    logic               hit_data;
    logic               ctrl_wr;
    logic               data_wait;
    logic               rd_no_data;
    dir_e               dir_q;
    logic [COUNT_W-1:0] count_q;

    // access phase of an apb transfer
    assign access     = psel & penable;

    assign hit_ctrl   = (paddr == ADDR_CTRL);
    assign hit_count  = (paddr == ADDR_COUNT);
    assign hit_status = (paddr == ADDR_STATUS);
    assign hit_data   = (paddr == ADDR_DATA);
    assign ctrl_wr    = access & pwrite & hit_ctrl;

    // stall a data write on a full fifo
    // stall a data read on an empty fifo only while a transfer can still fill it
    assign data_wait  = psel & hit_data & (pwrite ? fifo_full : (fifo_empty & busy));
    assign pready     = ~data_wait;

    // empty fifo and nothing running, the read can never be served
    assign rd_no_data = ~pwrite & fifo_empty & ~busy;
    assign pslverr    = access & ((~hit_ctrl & ~hit_count & ~hit_status & ~hit_data) |
                                  (hit_data & rd_no_data));

    // the fifo side is selected by direction in the top level
    assign fifo_push     = access & pwrite & hit_data & ~fifo_full;
    assign fifo_pop      = access & ~pwrite & hit_data & ~fifo_empty;
    assign fifo_wdata.lw = pwdata;

    // start is a single-cycle strobe on the ctrl write
    assign start      = ctrl_wr & pwdata[0];
    // new direction passes straight through so the packer latches it with start
    assign dir        = ctrl_wr ? dir_e'(pwdata[1]) : dir_q;
    assign count_load = count_q;

    always_ff @(posedge LS2CPU or negedge arst_n) begin
        if (!arst_n) begin
            dir_q   <= DIR_F2S;
            count_q <= '0;
        end else begin
            if (ctrl_wr) begin
                dir_q <= dir_e'(pwdata[1]);
            end
            if (access & pwrite & hit_count) begin
                count_q <= pwdata[COUNT_W-1:0];
            end
        end
    end

    // read mux
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[1] = dir_q;
        end else if (hit_count) begin
            // live count while running, loaded value otherwise
            prdata = busy ? 32'(count_left) : 32'(count_q);
        end else if (hit_status) begin
            prdata[2:0] = {fifo_full, fifo_empty, busy};
        end else if (hit_data && !fifo_empty) begin
            prdata = fifo_head.lw;
        end
    end

endmodule

//--- design/sdmac_datapath.sv
// top level of the scsi dma byte-lane datapath
// apb register block, longword fifo, lane packer and scsi byte port
// fifo push and pop sources are picked by transfer direction
module sdmac_datapath #(
    parameter int COUNT_W    = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic        LS2CPU,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        dreq,
    output logic        dack,
    output logic [7:0]  scsi_dout,
    output logic        scsi_doe,
    input  logic [7:0]  scsi_din
);
    import sdmac_pkg::*;

    logic               fifo_full;
    logic               fifo_empty;
    logic               fifo_push;
    logic               fifo_pop;
    sdmac_word_u        fifo_head;
    sdmac_word_u        fifo_wdata;
    logic               rg_push;
    logic               rg_pop;
    sdmac_word_u        rg_wdata;
    logic               pk_push;
    logic               pk_pop;
    sdmac_word_u        pk_wdata;
    logic               start;
    dir_e               dir;
    logic [COUNT_W-1:0] count_load;
    logic               busy;
    logic [COUNT_W-1:0] count_left;
    logic               tx_valid;
    logic [7:0]         tx_byte;
    logic               byte_taken;
    logic               rx_valid;
    logic [7:0]         rx_byte;
    logic               rx_mode;

    // host pushes on f2s and pops on s2f, the packer takes the other side
    assign fifo_push  = (dir == DIR_S2F) ? pk_push : rg_push;
    assign fifo_wdata = (dir == DIR_S2F) ? pk_wdata : rg_wdata;
    assign fifo_pop   = (dir == DIR_S2F) ? rg_pop : pk_pop;

    sdmac_apb_regs #(
        .COUNT_W (COUNT_W)
    ) sdmac_apb_regs_inst (
        .LS2CPU     (LS2CPU),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .fifo_head  (fifo_head),
        .fifo_push  (rg_push),
        .fifo_pop   (rg_pop),
        .fifo_wdata (rg_wdata),
        .start      (start),
        .dir        (dir),
        .count_load (count_load),
        .busy       (busy),
        .count_left (count_left)
    );

    sdmac_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdmac_word_fifo_inst (
        .LS2CPU (LS2CPU),
        .arst_n (arst_n),
        .push   (fifo_push),
        .wdata  (fifo_wdata),
        .pop    (fifo_pop),
        .rdata  (fifo_head),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

    scsi_lane_packer #(
        .COUNT_W (COUNT_W)
    ) scsi_lane_packer_inst (
        .LS2CPU     (LS2CPU),
        .arst_n     (arst_n),
        .start      (start),
        .dir        (dir),
        .count_load (count_load),
        .busy       (busy),
        .count_left (count_left),
        .fifo_head  (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .fifo_pop   (pk_pop),
        .fifo_push  (pk_push),
        .fifo_wdata (pk_wdata),
        .tx_valid   (tx_valid),
        .tx_byte    (tx_byte),
        .byte_taken (byte_taken),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .rx_mode    (rx_mode)
    );

    scsi_byte_port scsi_byte_port_inst (
        .LS2CPU     (LS2CPU),
        .arst_n     (arst_n),
        .rx_mode    (rx_mode),
        .tx_valid   (tx_valid),
        .tx_byte    (tx_byte),
        .byte_taken (byte_taken),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .dreq       (dreq),
        .dack       (dack),
        .scsi_dout  (scsi_dout),
        .scsi_doe   (scsi_doe),
        .scsi_din   (scsi_din)
    );

endmodule

//--- design/sdmac_pkg.sv
// shared definitions for the scsi dma byte-lane datapath
// fifo word union, transfer direction and apb register map
package sdmac_pkg;

    // one fifo entry, read as a longword or as four byte lanes
    // lane 3 is bits 31:24 and is the first byte on the scsi bus
    typedef union packed {
        logic [31:0]     lw;
        logic [3:0][7:0] lane;
    } sdmac_word_u;

    // transfer direction
    // f2s moves memory to scsi, s2f moves scsi to memory
    typedef enum logic {
        DIR_F2S = 1'b0,
        DIR_S2F = 1'b1
    } dir_e;

    // ctrl: bit 0 start, bit 1 direction
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    // byte count, reads back the live remaining count
    localparam logic [7:0] ADDR_COUNT  = 8'h04;
    // status: bit 0 busy, bit 1 fifo empty, bit 2 fifo full
    localparam logic [7:0] ADDR_STATUS = 8'h08;
    // fifo data port, write pushes and read pops
    localparam logic [7:0] ADDR_DATA   = 8'h0C;

endpackage

//--- design/sdmac_word_fifo.sv
// longword fifo for the scsi dma datapath
// circular buffer, pointers one bit wider than the address
// full and empty flags, head word shown combinationally
module sdmac_word_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   LS2CPU,
    input  logic                   arst_n,
    input  logic                   push,
    input  sdmac_pkg::sdmac_word_u wdata,
    input  logic                   pop,
    output sdmac_pkg::sdmac_word_u rdata,
    output logic                   full,
    output logic                   empty
);
    import sdmac_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    sdmac_word_u mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    // same address, wrap bits tell full from empty
    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // requests are flag-checked by the issuer, guard again here
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign rdata   = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge LS2CPU) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= wdata;
        end
    end

    always_ff @(posedge LS2CPU or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- sdmac_datapath.f
design/sdmac_pkg.sv
design/sdmac_apb_regs.sv
design/sdmac_word_fifo.sv
design/scsi_lane_packer.sv
design/scsi_byte_port.sv
design/sdmac_datapath.sv
bench/sdmac_datapath_tb.sv
